//--- Bender.yml
package:
  name: memsubsys

sources:
  - common/memPkg.sv
  - verilog/busArbiter.sv
  - memctrl/memCtrl.sv
  - memctrl/byteRam.sv
  - verilog/memSubsys.sv
  - target: test
    files:
      - verification/memSubsysTb.sv

//--- common/memPkg.sv
package memPkg;

    typedef logic [31:0] wordT;
    typedef logic [7:0] byteT;

    // bytes per access
    typedef enum logic [1:0] {
        SizeByte = 2'd0,
        SizeHalf = 2'd1,
        SizeWord = 2'd2
    } accessSizeT;

    // locked grant of the arbiter
    typedef enum logic [1:0] {
        OwnerNone  = 2'd0,
        OwnerFetch = 2'd1,
        OwnerData  = 2'd2
    } ownerT;

    function automatic logic [2:0] sizeBytes(accessSizeT size);
        logic [2:0] count;
        case (size)
            SizeByte: count = 3'd1;
            SizeHalf: count = 3'd2;
            default:  count = 3'd4;
        endcase
        return count;
    endfunction

endpackage

//--- memSubsys.f
common/memPkg.sv
verilog/busArbiter.sv
memctrl/memCtrl.sv
memctrl/byteRam.sv
verilog/memSubsys.sv
verification/memSubsysTb.sv

//--- memctrl/byteRam.sv
`timescale 1ns/1ps

module byteRam #(
    parameter int AddrWidth = 12,
    parameter int MemDepth  = 4096
) (
    input  logic                   clk,
    input  logic                   i_we,
    input  logic [AddrWidth-1:0]   i_adr,
    input  memPkg::byteT           i_datW,
    output memPkg::byteT           o_datR
);
    import memPkg::*;

    byteT mem [MemDepth];

    always_ff @(posedge clk) begin
        if (i_we) begin
            mem[i_adr] <= i_datW;
        end
    end

    // registered read, old contents on a same-cycle write
    always_ff @(posedge clk) begin
        o_datR <= mem[i_adr];
    end

endmodule

//--- memctrl/memCtrl.sv
`timescale 1ns/1ps

module memCtrl #(
    parameter int AddrWidth = 12
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   i_ioFull,

    input  logic                   i_reqValid,
    input  logic                   i_reqWe,
    input  logic [AddrWidth-1:0]   i_reqAdr,
    input  memPkg::accessSizeT     i_reqSize,
    input  memPkg::wordT           i_reqDatW,
    output logic                   o_reqDone,
    output memPkg::wordT           o_reqDatR,

    output logic                   o_ramWe,
    output logic [AddrWidth-1:0]   o_ramAdr,
    output memPkg::byteT           o_ramDatW,
    input  memPkg::byteT           i_ramDatR
);
    import memPkg::*;

    logic [2:0] stage;
    logic [2:0] numBytes;
    logic [2:0] lastStage;
    logic [2:0] adrStage;
    logic [1:0] lastLane;
    logic       isLoad;
    logic       stepEn;
    logic       done;
    wordT       asmWord;
    wordT       loadWord;

    assign numBytes = sizeBytes(i_reqSize);
    assign isLoad   = i_reqValid && !i_reqWe;
    assign stepEn   = i_reqValid && !i_ioFull;

    // loads need one extra cycle for the RAM read latency
    assign lastStage = isLoad ? numBytes : numBytes - 3'd1;
    assign done      = stepEn && (stage == lastStage);

    // lane of the byte currently on i_ramDatR
    assign lastLane = 2'(stage - 3'd1);

    // while a load is stalled, re-read the byte in flight so it stays valid
    always_comb begin
        if (isLoad && i_ioFull && stage != 3'd0) begin
            adrStage = stage - 3'd1;
        end else begin
            adrStage = stage;
        end
    end

    assign o_ramAdr  = i_reqAdr + AddrWidth'(adrStage);
    assign o_ramWe   = stepEn && i_reqWe;
    assign o_ramDatW = i_reqDatW[{stage[1:0], 3'b000} +: 8];
    assign o_reqDone = done;

    always_ff @(posedge clk) begin
        if (rst) begin
            stage <= 3'd0;
        end else if (stepEn) begin
            if (done) begin
                stage <= 3'd0;
            end else begin
                stage <= stage + 3'd1;
            end
        end
    end

    // little-endian assembly of returned bytes
    always_ff @(posedge clk) begin
        if (stepEn && isLoad && stage != 3'd0 && !done) begin
            asmWord[{lastLane, 3'b000} +: 8] <= i_ramDatR;
        end
    end

    // last byte comes straight from the RAM
    always_comb begin
        loadWord = asmWord;
        loadWord[{lastLane, 3'b000} +: 8] = i_ramDatR;
    end

    always_comb begin
        o_reqDatR = '0;
        if (done && isLoad) begin
            case (i_reqSize)
                SizeByte: o_reqDatR = {24'd0, loadWord[7:0]};
                SizeHalf: o_reqDatR = {16'd0, loadWord[15:0]};
                default:  o_reqDatR = loadWord;
            endcase
        end
    end

    stageInRange: assert property (@(posedge clk) disable iff (rst)
        i_reqValid |-> stage <= sizeBytes(i_reqSize))
        else $error("byte stage beyond request size");

    idleStageZero: assert property (@(posedge clk) disable iff (rst)
        !i_reqValid |-> stage == 3'd0)
        else $error("byte stage not cleared between requests");

    // returned byte survives a stalled load
    stallHoldsByte: assert property (@(posedge clk) disable iff (rst)
        (isLoad && i_ioFull && stage != 3'd0) |=> $stable(i_ramDatR))
        else $error("byte in flight lost during io stall");

endmodule

//--- verification/memSubsysTb.sv
`timescale 1ns/1ps

module memSubsysTb;
    import memPkg::*;

    localparam int AddrWidth = 12;
    localparam int MemDepth  = 4096;
    localparam int ClkPeriod = 100;
    localparam int NumWords  = 8;
    localparam int NumSub    = 6;
    localparam int NumFetch  = 6;
    localparam int NumArb    = 4;
    localparam int NumStall  = 8;
    localparam int MaxStall  = 24;
    localparam int NumReq    = 2 * NumWords + 5 * NumSub + NumFetch + 2 * NumArb + 2 * NumStall;
    localparam int WatchdogCycles = 5 + NumReq * (6 + MaxStall) + 100;

    logic clk;
    logic rst;
    logic i_ioFull;
    logic i_fetchCyc;
    logic i_fetchStb;
    logic [AddrWidth-1:0] i_fetchAdr;
    logic o_fetchAck;
    wordT o_fetchDat;
    logic i_dataCyc;
    logic i_dataStb;
    logic i_dataWe;
    logic [AddrWidth-1:0] i_dataAdr;
    accessSizeT i_dataSize;
    wordT i_dataDatW;
    logic o_dataAck;
    wordT o_dataDatR;

    byteT model [MemDepth];
    logic [AddrWidth-1:0] storedAdr [$];
    integer seed = 13135;
    int errorCount = 0;
    int requestCount = 0;
    int testCount = 0;
    int spanLeft = 0;
    logic stallOn = 1'b0;
    logic started = 1'b0;
    logic quietWatch = 1'b0;
    wordT dataExp = '0;
    wordT fetchExp = '0;
    time dataAckTime;
    time fetchAckTime;

    memSubsys #(
        .AddrWidth (AddrWidth),
        .MemDepth  (MemDepth)
    ) dut0 (
        .clk        (clk),
        .rst        (rst),
        .i_ioFull   (i_ioFull),
        .i_fetchCyc (i_fetchCyc),
        .i_fetchStb (i_fetchStb),
        .i_fetchAdr (i_fetchAdr),
        .o_fetchAck (o_fetchAck),
        .o_fetchDat (o_fetchDat),
        .i_dataCyc  (i_dataCyc),
        .i_dataStb  (i_dataStb),
        .i_dataWe   (i_dataWe),
        .i_dataAdr  (i_dataAdr),
        .i_dataSize (i_dataSize),
        .i_dataDatW (i_dataDatW),
        .o_dataAck  (o_dataAck),
        .o_dataDatR (o_dataDatR)
    );

    initial begin
        clk = 1'b0;
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    initial begin
        #(WatchdogCycles * ClkPeriod);
        $display("timeout: requests did not complete within the expected run length");
        $display("RESULT: FAIL");
        $finish;
    end

    dataReadOk: assert property (@(posedge clk) disable iff (rst)
        (o_dataAck && !i_dataWe) |-> o_dataDatR == dataExp)
        else begin
            errorCount++;
            $display("mismatch at %0t: data read expected %h got %h",
                     $time, $sampled(dataExp), $sampled(o_dataDatR));
        end

    fetchReadOk: assert property (@(posedge clk) disable iff (rst)
        o_fetchAck |-> o_fetchDat == fetchExp)
        else begin
            errorCount++;
            $display("mismatch at %0t: fetch expected %h got %h",
                     $time, $sampled(fetchExp), $sampled(o_fetchDat));
        end

    acksExclusive: assert property (@(posedge clk) disable iff (rst)
        !(o_dataAck && o_fetchAck))
        else begin
            errorCount++;
            $display("fetch and data ack were high in the same cycle");
        end

    noAckInStall: assert property (@(posedge clk) disable iff (rst)
        i_ioFull |-> !o_dataAck && !o_fetchAck)
        else begin
            errorCount++;
            $display("an ack arrived while the io buffer was full");
        end

    // covers reset and the idle time before the first request
    quietBeforeUse: assert property (@(posedge clk)
        (quietWatch && !started) |-> !o_dataAck && !o_fetchAck)
        else begin
            errorCount++;
            $display("an ack appeared before any request was made");
        end

    function automatic wordT modelRead(input logic [AddrWidth-1:0] adr, input accessSizeT size);
        wordT w;
        logic [AddrWidth-1:0] a;
        w = '0;
        for (int k = 0; k < int'(sizeBytes(size)); k++) begin
            a = adr + AddrWidth'(k);
            w[8*k +: 8] = model[a];
        end
        return w;
    endfunction

    function automatic logic [AddrWidth-1:0] pickStored();
        return storedAdr[{$random(seed)} % storedAdr.size()];
    endfunction

    // random on and off spans of the io stall
    task automatic pickStall();
        if (spanLeft == 0) begin
            i_ioFull = !i_ioFull;
            spanLeft = 1 + ({$random(seed)} % 4);
        end
        spanLeft--;
    endtask

    task automatic dataRequest(input logic we, input logic [AddrWidth-1:0] adr,
                               input accessSizeT size, input wordT datW);
        logic seen;
        logic [AddrWidth-1:0] a;
        started = 1'b1;
        if (!we) begin
            dataExp = modelRead(adr, size);
        end
        i_dataCyc  = 1'b1;
        i_dataStb  = 1'b1;
        i_dataWe   = we;
        i_dataAdr  = adr;
        i_dataSize = size;
        i_dataDatW = datW;
        seen = 1'b0;
        while (!seen) begin
            if (stallOn) begin
                pickStall();
            end
            @(posedge clk);
            seen = o_dataAck;
            @(negedge clk);
        end
        dataAckTime = $time;
        i_dataCyc = 1'b0;
        i_dataStb = 1'b0;
        i_dataWe  = 1'b0;
        if (we) begin
            for (int k = 0; k < int'(sizeBytes(size)); k++) begin
                a = adr + AddrWidth'(k);
                model[a] = datW[8*k +: 8];
            end
        end
        requestCount++;
    endtask

    task automatic fetchRequest(input logic [AddrWidth-1:0] adr);
        logic seen;
        started = 1'b1;
        fetchExp = modelRead(adr, SizeWord);
        i_fetchCyc = 1'b1;
        i_fetchStb = 1'b1;
        i_fetchAdr = adr;
        seen = 1'b0;
        while (!seen) begin
            @(posedge clk);
            seen = o_fetchAck;
            @(negedge clk);
        end
        fetchAckTime = $time;
        i_fetchCyc = 1'b0;
        i_fetchStb = 1'b0;
        requestCount++;
    endtask

    task automatic reportTest(input string name);
        testCount++;
        $display("test %0s finished, errors so far %0d", name, errorCount);
    endtask

    initial begin
        logic [AddrWidth-1:0] adr;
        logic [AddrWidth-1:0] fAdr;
        logic [1:0] off;
        rst = 1'b1;
        i_ioFull = 1'b0;
        i_fetchCyc = 1'b0;
        i_fetchStb = 1'b0;
        i_fetchAdr = '0;
        i_dataCyc = 1'b0;
        i_dataStb = 1'b0;
        i_dataWe = 1'b0;
        i_dataAdr = '0;
        i_dataSize = SizeWord;
        i_dataDatW = '0;
        @(negedge clk);
        quietWatch = 1'b1;
        repeat (4) @(negedge clk);
        rst = 1'b0;
        repeat (3) @(negedge clk);
        reportTest("reset state");

        for (int i = 0; i < NumWords; i++) begin
            adr = AddrWidth'(({$random(seed)} % (MemDepth / 4)) * 4);
            storedAdr.push_back(adr);
            dataRequest(1'b1, adr, SizeWord, $random(seed));
            dataRequest(1'b0, adr, SizeWord, '0);
        end
        reportTest("word round trip");

        for (int i = 0; i < NumSub; i++) begin
            adr = pickStored();
            off = 2'({$random(seed)} % 4);
            dataRequest(1'b1, adr + AddrWidth'(off), SizeByte, $random(seed));
            dataRequest(1'b1, adr + AddrWidth'({off[1], 1'b0}), SizeHalf, $random(seed));
            dataRequest(1'b0, adr + AddrWidth'(off), SizeByte, '0);
            dataRequest(1'b0, adr + AddrWidth'({off[1], 1'b0}), SizeHalf, '0);
            // whole word shows which lanes changed
            dataRequest(1'b0, adr, SizeWord, '0);
        end
        reportTest("sub-word access");

        for (int i = 0; i < NumFetch; i++) begin
            fetchRequest(pickStored());
        end
        reportTest("fetch path");

        for (int i = 0; i < NumArb; i++) begin
            adr = pickStored();
            fAdr = pickStored();
            fork
                dataRequest(1'b0, adr, SizeWord, '0);
                fetchRequest(fAdr);
            join
            assert (dataAckTime < fetchAckTime) else begin
                errorCount++;
                $display("fetch was served before the data request raised with it");
            end
        end
        reportTest("arbitration");

        stallOn = 1'b1;
        for (int i = 0; i < NumStall; i++) begin
            adr = pickStored();
            dataRequest(1'b1, adr, SizeWord, $random(seed));
            dataRequest(1'b0, adr, SizeWord, '0);
        end
        stallOn = 1'b0;
        i_ioFull = 1'b0;
        spanLeft = 0;
        reportTest("io stall");

        repeat (3) @(negedge clk);
        $display("tests %0d, requests %0d, errors %0d", testCount, requestCount, errorCount);
        if (errorCount == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- verilog/busArbiter.sv
`timescale 1ns/1ps

module busArbiter #(
    parameter int AddrWidth = 12
) (
    input  logic                   clk,
    input  logic                   rst,

    input  logic                   i_fetchCyc,
    input  logic                   i_fetchStb,
    input  logic [AddrWidth-1:0]   i_fetchAdr,
    output logic                   o_fetchAck,
    output memPkg::wordT           o_fetchDat,

    input  logic                   i_dataCyc,
    input  logic                   i_dataStb,
    input  logic                   i_dataWe,
    input  logic [AddrWidth-1:0]   i_dataAdr,
    input  memPkg::accessSizeT     i_dataSize,
    input  memPkg::wordT           i_dataDatW,
    output logic                   o_dataAck,
    output memPkg::wordT           o_dataDatR,

    output logic                   o_reqValid,
    output logic                   o_reqWe,
    output logic [AddrWidth-1:0]   o_reqAdr,
    output memPkg::accessSizeT     o_reqSize,
    output memPkg::wordT           o_reqDatW,
    input  logic                   i_reqDone,
    input  memPkg::wordT           i_reqDatR
);
    import memPkg::*;

    ownerT owner;
    logic  fetchReq;
    logic  dataReq;
    logic  dataOwns;

    assign fetchReq = i_fetchCyc && i_fetchStb;
    assign dataReq  = i_dataCyc && i_dataStb;
    assign dataOwns = (owner == OwnerData);

    // grant stays locked until the controller reports done
    always_ff @(posedge clk) begin
        if (rst) begin
            owner <= OwnerNone;
        end else if (owner == OwnerNone) begin
            if (dataReq) begin
                owner <= OwnerData;
            end else if (fetchReq) begin
                owner <= OwnerFetch;
            end
        end else if (i_reqDone) begin
            owner <= OwnerNone;
        end
    end

    // fetch is always a word read
    assign o_reqValid = (owner != OwnerNone);
    assign o_reqWe    = dataOwns && i_dataWe;
    assign o_reqAdr   = dataOwns ? i_dataAdr : i_fetchAdr;
    assign o_reqSize  = dataOwns ? i_dataSize : SizeWord;
    assign o_reqDatW  = dataOwns ? i_dataDatW : '0;

    assign o_fetchAck = i_reqDone && (owner == OwnerFetch);
    assign o_dataAck  = i_reqDone && dataOwns;
    assign o_fetchDat = (owner == OwnerFetch) ? i_reqDatR : '0;
    assign o_dataDatR = dataOwns ? i_reqDatR : '0;

    // a granted master holds its request until done
    reqHeld: assert property (@(posedge clk) disable iff (rst)
        (o_reqValid && !i_reqDone) |=> $stable(o_reqAdr) && $stable(o_reqSize))
        else $error("request fields changed before done");

    doneNeedsOwner: assert property (@(posedge clk) disable iff (rst)
        i_reqDone |-> owner != OwnerNone)
        else $error("controller done without a granted request");

endmodule

//--- verilog/memSubsys.sv
`timescale 1ns/1ps

module memSubsys #(
    parameter int AddrWidth = 12,
    parameter int MemDepth  = 4096
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   i_ioFull,

    input  logic                   i_fetchCyc,
    input  logic                   i_fetchStb,
    input  logic [AddrWidth-1:0]   i_fetchAdr,
    output logic                   o_fetchAck,
    output memPkg::wordT           o_fetchDat,

    input  logic                   i_dataCyc,
    input  logic                   i_dataStb,
    input  logic                   i_dataWe,
    input  logic [AddrWidth-1:0]   i_dataAdr,
    input  memPkg::accessSizeT     i_dataSize,
    input  memPkg::wordT           i_dataDatW,
    output logic                   o_dataAck,
    output memPkg::wordT           o_dataDatR
);
    import memPkg::*;

    logic                 reqValid;
    logic                 reqWe;
    logic [AddrWidth-1:0] reqAdr;
    accessSizeT           reqSize;
    wordT                 reqDatW;
    logic                 reqDone;
    wordT                 reqDatR;

    logic                 ramWe;
    logic [AddrWidth-1:0] ramAdr;
    byteT                 ramDatW;
    byteT                 ramDatR;

    busArbiter #(
        .AddrWidth (AddrWidth)
    ) arb0 (
        .clk        (clk),
        .rst        (rst),
        .i_fetchCyc (i_fetchCyc),
        .i_fetchStb (i_fetchStb),
        .i_fetchAdr (i_fetchAdr),
        .o_fetchAck (o_fetchAck),
        .o_fetchDat (o_fetchDat),
        .i_dataCyc  (i_dataCyc),
        .i_dataStb  (i_dataStb),
        .i_dataWe   (i_dataWe),
        .i_dataAdr  (i_dataAdr),
        .i_dataSize (i_dataSize),
        .i_dataDatW (i_dataDatW),
        .o_dataAck  (o_dataAck),
        .o_dataDatR (o_dataDatR),
        .o_reqValid (reqValid),
        .o_reqWe    (reqWe),
        .o_reqAdr   (reqAdr),
        .o_reqSize  (reqSize),
        .o_reqDatW  (reqDatW),
        .i_reqDone  (reqDone),
        .i_reqDatR  (reqDatR)
    );

    memCtrl #(
        .AddrWidth (AddrWidth)
    ) ctrl0 (
        .clk        (clk),
        .rst        (rst),
        .i_ioFull   (i_ioFull),
        .i_reqValid (reqValid),
        .i_reqWe    (reqWe),
        .i_reqAdr   (reqAdr),
        .i_reqSize  (reqSize),
        .i_reqDatW  (reqDatW),
        .o_reqDone  (reqDone),
        .o_reqDatR  (reqDatR),
        .o_ramWe    (ramWe),
        .o_ramAdr   (ramAdr),
        .o_ramDatW  (ramDatW),
        .i_ramDatR  (ramDatR)
    );

    byteRam #(
        .AddrWidth (AddrWidth),
        .MemDepth  (MemDepth)
    ) ram0 (
        .clk    (clk),
        .i_we   (ramWe),
        .i_adr  (ramAdr),
        .i_datW (ramDatW),
        .o_datR (ramDatR)
    );

endmodule
